// ==== Makefile ====
# Verilator build and run of the execute stage testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run ex_tb and check sim.log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module ex_tb \
		-f compile.f --Mdir obj_dir -o ex_sim
	./obj_dir/ex_sim | tee sim.log
	@grep -qF '*** PASSED ***' sim.log && echo "Result: pass" || \
		(echo "Result: fail"; exit 1)

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+logic
logic/isa_pkg.sv
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_mul.sv
logic/ex_acc.sv
logic/ex_control.sv
logic/ex_stage.sv
dv/ex_checker.sv
dv/ex_asserts.sv
dv/ex_tb.sv

// ==== dv/ex_asserts.sv ====
/*
 * Protocol assertions for the execute stage, bound into ex_stage.
 * Reset quiet output, fixed two cycle latency, no register write for
 * accumulator writes.
 */

`timescale 1ns/1ps
`default_nettype none

module ex_asserts (
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    input  logic                outValid,
    input  logic                issueValid,
    input  ex_pkg::exIssue_t    issueQ,
    input  ex_pkg::exResult_t   ctrlResult
);
    import isa_pkg::*;

    logic accFunct;

    // MULT group and MTHI/MTLO in SPECIAL, MADD group in SPECIAL2
    assign accFunct = (issueQ.opClass == SPECIAL)
        ? (issueQ.funct inside {MULT, MULTU, MTHI, MTLO})
        : (funct2_e'(issueQ.funct) inside {MADD, MADDU, MSUB});

    resetQuiet: assert property (@(posedge clk) !rstN |-> !outValid)
        else $error("outValid high while reset is asserted");

    fixedLatency: assert property (@(posedge clk) disable iff (!rstN)
        outValid == $past(inValid, 2))
        else $error("outValid does not follow inValid by two cycles");

    accNoRegWrite: assert property (@(posedge clk) disable iff (!rstN)
        (issueValid && accFunct) |-> !ctrlResult.regWrite)
        else $error("regWrite set on an accumulator write");

endmodule

bind ex_stage ex_asserts uAsserts (
    .clk        (clk),
    .rstN       (rstN),
    .inValid    (inValid),
    .outValid   (outValid),
    .issueValid (issueValid),
    .issueQ     (issueQ),
    .ctrlResult (ctrlResult)
);

`default_nettype wire

// ==== dv/ex_checker.sv ====
/*
 * Scoreboard for the execute stage. Queues the expected result of every
 * valid issue and compares each outValid result in order, including the
 * two cycle latency. Prints one line per test.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_checker (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    inValid,
    input  ex_pkg::exIssue_t        inInstr,
    input  logic [`EX_XLEN-1:0]     expValue,
    input  ex_pkg::exFlags_t        expFlags,
    input  logic                    expRegWrite,
    input  logic                    outValid,
    input  ex_pkg::exResult_t       outResult,
    output int                      checkedCount,
    output int                      errorCount
);
    import ex_pkg::*;

    localparam int LATENCY = 2;

    typedef struct packed {
        exResult_t      result;
        logic [31:0]    issueCycle;
    } pending_t;

    pending_t       pendQ[$];
    pending_t       head;
    pending_t       entry;
    logic [31:0]    cycle;

    task automatic compareResult(input pending_t e);
        logic [31:0] delay;
        delay = cycle - e.issueCycle;
        if (delay != LATENCY)
            $display("Test %0d: result came %0d cycles after issue instead of %0d",
                     checkedCount, delay, LATENCY);
        else if (outResult.value !== e.result.value)
            $display("FAILED test %0d: value got %h expected %h",
                     checkedCount, outResult.value, e.result.value);
        else if (outResult.flags !== e.result.flags)
            $display("FAILED test %0d: flags got %h expected %h",
                     checkedCount, outResult.flags, e.result.flags);
        else if (outResult.dest !== e.result.dest)
            $display("FAILED test %0d: dest got %h expected %h",
                     checkedCount, outResult.dest, e.result.dest);
        else if (outResult.regWrite !== e.result.regWrite)
            $display("FAILED test %0d: regWrite got %h expected %h",
                     checkedCount, outResult.regWrite, e.result.regWrite);
        else if (outResult.pc !== e.result.pc)
            $display("FAILED test %0d: pc got %h expected %h",
                     checkedCount, outResult.pc, e.result.pc);
        else
            $display("Test %0d ok  pc %h value %h", checkedCount, outResult.pc,
                     outResult.value);
        if ((delay != LATENCY) || (outResult !== e.result))
            errorCount++;
        checkedCount++;
    endtask

    // --------------------------------------------------
    // Sample on the rising edge, before the DUT registers move
    // --------------------------------------------------
    always @(posedge clk)
    begin
        if (!rstN)
        begin
            cycle        = '0;
            checkedCount = 0;
            errorCount   = 0;
            pendQ.delete();
        end
        else
        begin
            if (outValid)
            begin
                if (pendQ.size() == 0)
                begin
                    $display("Result at cycle %0d arrived with no instruction outstanding",
                             cycle);
                    errorCount++;
                end
                else
                begin
                    head = pendQ.pop_front();
                    compareResult(head);
                end
            end
            if (inValid)
            begin
                entry.result.value    = expValue;
                entry.result.flags    = expFlags;
                entry.result.dest     = inInstr.dest;   // Passes through
                entry.result.regWrite = expRegWrite;
                entry.result.pc       = inInstr.pc;
                entry.issueCycle      = cycle;
                pendQ.push_back(entry);
            end
            cycle = cycle + 1;
        end
    end

endmodule

`default_nettype wire

// ==== dv/ex_tb.sv ====
/*
 * Testbench of the execute stage. Applies a table of instructions with
 * hand worked results, one per cycle with random idle gaps, and leaves
 * the comparing to ex_checker.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_tb;
    import isa_pkg::*;
    import ex_pkg::*;

    localparam int RESET_CYCLES = 10;
    localparam int DRAIN_LIMIT  = 50;
    localparam int MAX_GAP      = 2;

    typedef struct packed {
        exIssue_t               instr;
        logic [`EX_XLEN-1:0]    expValue;
        exFlags_t               expFlags;
        logic                   expRegWrite;
        logic                   tight;      // No idle gap after this entry
    } vector_t;

    logic                   clk;
    logic                   rstN;
    logic                   inValid;
    exIssue_t               inInstr;
    logic                   outValid;
    exResult_t              outResult;
    logic [`EX_XLEN-1:0]    expValue;
    exFlags_t               expFlags;
    logic                   expRegWrite;
    int                     checkedCount;
    int                     errorCount;
    vector_t                vecs[$];

    ex_stage uut (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inInstr   (inInstr),
        .outValid  (outValid),
        .outResult (outResult)
    );

    ex_checker uChecker (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .inInstr      (inInstr),
        .expValue     (expValue),
        .expFlags     (expFlags),
        .expRegWrite  (expRegWrite),
        .outValid     (outValid),
        .outResult    (outResult),
        .checkedCount (checkedCount),
        .errorCount   (errorCount)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    task automatic addVec(input opClass_e cls, input logic [`EX_FUNCTW-1:0] fn,
                          input logic [`EX_XLEN-1:0] a, input logic [`EX_XLEN-1:0] b,
                          input logic [`EX_XLEN-1:0] expV, input exFlags_t expF,
                          input logic expRw);
        vector_t v;
        v                = '0;
        v.instr.opClass  = cls;
        v.instr.funct    = funct_e'(fn);
        v.instr.a        = a;
        v.instr.b        = b;
        v.instr.dest     = `EX_REGW'(vecs.size() + 1);
        v.instr.regWrite = 1'b1;
        v.instr.pc       = `EX_XLEN'(32'h0040_0000 + 4 * vecs.size());
        v.expValue       = expV;
        v.expFlags       = expF;
        v.expRegWrite    = expRw;
        vecs.push_back(v);
    endtask

    // --------------------------------------------------
    // Stimulus table, flags written as c z o n
    // --------------------------------------------------
    task automatic buildTable();
        addVec(SPECIAL, ADD,  32'h7fff_ffff, 32'h1, 32'h8000_0000, 4'b0011, 1'b1);
        addVec(SPECIAL, ADDU, 32'h7fff_ffff, 32'h1, 32'h8000_0000, 4'b0001, 1'b1);
        addVec(SPECIAL, SUB,  32'h0, 32'h1, 32'hffff_ffff, 4'b0001, 1'b1);
        addVec(SPECIAL, SUBU, 32'h0, 32'h1, 32'hffff_ffff, 4'b0001, 1'b1);
        addVec(SPECIAL, ADD,  32'hffff_ffff, 32'h1, 32'h0, 4'b1100, 1'b1);
        addVec(SPECIAL, SUB,  32'h5, 32'h5, 32'h0, 4'b1100, 1'b1);
        addVec(SPECIAL, SUB,  32'h8000_0000, 32'h1, 32'h7fff_ffff, 4'b1010, 1'b1);
        addVec(SPECIAL, ADDU, 32'h8000_0000, 32'h8000_0000, 32'h0, 4'b1100, 1'b1);
        addVec(SPECIAL, ADD,  32'h3, 32'h4, 32'h7, 4'b0000, 1'b0);
        vecs[vecs.size() - 1].instr.regWrite = 1'b0;  // Write not requested
        // Logic, compares, shifts, counts
        addVec(SPECIAL, AND,  32'hf0f0_1234, 32'h0ff0_ffff, 32'h00f0_1234, 4'b0000, 1'b1);
        addVec(SPECIAL, OR,   32'hf000_0000, 32'h0000_000f, 32'hf000_000f, 4'b0001, 1'b1);
        addVec(SPECIAL, XOR,  32'haaaa_5555, 32'haaaa_5555, 32'h0, 4'b0100, 1'b1);
        addVec(SPECIAL, NOR,  32'h0f0f_0000, 32'h00f0_ffff, 32'hf000_0000, 4'b0001, 1'b1);
        addVec(SPECIAL, SLT,  32'hffff_fffe, 32'h1, 32'h1, 4'b0000, 1'b1);
        addVec(SPECIAL, SLTU, 32'hffff_fffe, 32'h1, 32'h0, 4'b0100, 1'b1);
        addVec(SPECIAL, SLLV, 32'h0000_0024, 32'h0000_00f1, 32'h0000_0f10, 4'b0000, 1'b1);
        addVec(SPECIAL, SRLV, 32'h8, 32'h8000_0000, 32'h0080_0000, 4'b0000, 1'b1);
        addVec(SPECIAL, SRAV, 32'h8, 32'h8000_0000, 32'hff80_0000, 4'b0001, 1'b1);
        addVec(SPECIAL2, CLZ, 32'h0001_0000, 32'h0, 32'd15, 4'b0000, 1'b1);
        addVec(SPECIAL2, CLZ, 32'h0, 32'h0, 32'd32, 4'b0000, 1'b1);
        addVec(SPECIAL2, CLO, 32'hff00_0000, 32'h0, 32'd8, 4'b0000, 1'b1);
        addVec(SPECIAL2, CLO, 32'h7fff_ffff, 32'h0, 32'd0, 4'b0100, 1'b1);
        // HI/LO sequences, -2 * 3 then unsigned
        addVec(SPECIAL, MULT,  32'hffff_fffe, 32'h3, 32'hffff_fffa, 4'b0001, 1'b0);
        vecs[vecs.size() - 1].tight = 1'b1;          // MFHI right behind
        addVec(SPECIAL, MFHI,  32'h0, 32'h0, 32'hffff_ffff, 4'b0001, 1'b1);
        addVec(SPECIAL, MFLO,  32'h0, 32'h0, 32'hffff_fffa, 4'b0001, 1'b1);
        addVec(SPECIAL, MULTU, 32'hffff_fffe, 32'h3, 32'hffff_fffa, 4'b0000, 1'b0);
        addVec(SPECIAL, MFHI,  32'h0, 32'h0, 32'h2, 4'b0000, 1'b1);
        addVec(SPECIAL2, MADD, 32'h0001_0000, 32'h0001_0000, 32'hffff_fffa, 4'b0000, 1'b0);
        addVec(SPECIAL, MFHI,  32'h0, 32'h0, 32'h3, 4'b0000, 1'b1);
        addVec(SPECIAL2, MSUB, 32'h2, 32'h7fff_fffd, 32'h0, 4'b0000, 1'b0);  // HI stays 3
        addVec(SPECIAL, MFLO,  32'h0, 32'h0, 32'h0, 4'b0100, 1'b1);
        addVec(SPECIAL, MFHI,  32'h0, 32'h0, 32'h3, 4'b0000, 1'b1);
        addVec(SPECIAL2, MADDU, 32'hffff_fffc, 32'h1, 32'hffff_fffc, 4'b0000, 1'b0);
        addVec(SPECIAL, MFHI,  32'h0, 32'h0, 32'h3, 4'b0000, 1'b1);
        addVec(SPECIAL, MULT,  32'h0, 32'h5, 32'h0, 4'b0100, 1'b0);
        // Direct HI/LO writes
        addVec(SPECIAL, MTHI,  32'h8765_4321, 32'h0, 32'h0, 4'b0001, 1'b0);
        addVec(SPECIAL, MTLO,  32'h1234_5678, 32'h0, 32'h1234_5678, 4'b0001, 1'b0);
        addVec(SPECIAL, MFHI,  32'h0, 32'h0, 32'h8765_4321, 4'b0001, 1'b1);
        addVec(SPECIAL, MFLO,  32'h0, 32'h0, 32'h1234_5678, 4'b0000, 1'b1);
        // MUL leaves HI/LO alone
        addVec(SPECIAL2, MUL,  32'h0001_0000, 32'h0001_0000, 32'h0, 4'b1110, 1'b1);
        addVec(SPECIAL2, MUL,  32'hffff_fffd, 32'h5, 32'hffff_fff1, 4'b1011, 1'b1);
        addVec(SPECIAL2, MUL,  32'h7, 32'h6, 32'h2a, 4'b0000, 1'b1);
        addVec(SPECIAL, MFLO,  32'h0, 32'h0, 32'h1234_5678, 4'b0000, 1'b1);
        addVec(SPECIAL, MFHI,  32'h0, 32'h0, 32'h8765_4321, 4'b0001, 1'b1);
        // Unknown funct codes
        addVec(SPECIAL,  6'h3f, 32'h1, 32'h2, 32'h0, 4'b0000, 1'b0);
        addVec(SPECIAL2, 6'h3f, 32'h1, 32'h2, 32'h0, 4'b0000, 1'b0);
    endtask

    // Idle slot carrying a MULT that must not touch HI/LO
    task automatic driveIdle();
        @(negedge clk);
        inValid         = 1'b0;
        inInstr.opClass = SPECIAL;
        inInstr.funct   = MULT;
        inInstr.a       = $urandom();
        inInstr.b       = $urandom();
    endtask

    initial
    begin
        int unsigned    seedInit;
        int             gap;
        int             waitCycles;

        seedInit    = $urandom(32'h9e79_c5d6);
        rstN        = 1'b0;
        inValid     = 1'b0;
        inInstr     = '0;
        expValue    = '0;
        expFlags    = '0;
        expRegWrite = 1'b0;
        buildTable();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;

        for (int i = 0; i < vecs.size(); i++)
        begin
            @(negedge clk);
            inValid     = 1'b1;
            inInstr     = vecs[i].instr;
            expValue    = vecs[i].expValue;
            expFlags    = vecs[i].expFlags;
            expRegWrite = vecs[i].expRegWrite;
            gap = vecs[i].tight ? 0 : int'($urandom_range(MAX_GAP, 0));
            repeat (gap) driveIdle();
        end
        driveIdle();

        // Drain the last results
        waitCycles = 0;
        while ((checkedCount < vecs.size()) && (waitCycles < DRAIN_LIMIT))
        begin
            @(negedge clk);
            waitCycles++;
        end
        if (checkedCount < vecs.size())
            $display("Timeout: only %0d of %0d results arrived", checkedCount, vecs.size());

        $display("Tests %0d, checked %0d, errors %0d", vecs.size(), checkedCount,
                 errorCount);
        if ((errorCount == 0) && (checkedCount == vecs.size()))
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/ex_acc.sv ====
/*
 * HI/LO accumulator of the execute stage.
 * Presents the next HI:LO and its flags in the same cycle so the control
 * block can report them, and commits on the clock edge when accWrite is
 * not NONE.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_acc (
    input  logic                    clk,
    input  logic                    rstN,
    input  ex_pkg::accOp_e          accWrite,
    input  logic [2*`EX_XLEN-1:0]   product,
    input  logic [`EX_XLEN-1:0]     a,
    output logic [`EX_XLEN-1:0]     hi,
    output logic [`EX_XLEN-1:0]     lo,
    output logic [`EX_XLEN-1:0]     nextLo,
    output ex_pkg::exFlags_t        nextFlags
);
    import ex_pkg::*;

    localparam int MSB = `EX_XLEN - 1;

    logic [2*`EX_XLEN-1:0] accQ;    // HI in upper half
    logic [2*`EX_XLEN-1:0] accNext;

    // --------------------------------------------------
    // Next value
    // --------------------------------------------------
    always_comb
    begin
        case (accWrite)
            LOAD_PRODUCT: accNext = product;
            ADD_PRODUCT:  accNext = accQ + product;
            SUB_PRODUCT:  accNext = accQ - product;
            WRITE_HI:     accNext = {a, accQ[MSB:0]};
            WRITE_LO:     accNext = {accQ[2*`EX_XLEN-1:`EX_XLEN], a};
            default:      accNext = accQ;
        endcase
    end

    assign nextLo      = accNext[MSB:0];
    assign nextFlags.c = 1'b0;
    assign nextFlags.o = 1'b0;
    assign nextFlags.z = (accNext == '0);         // Whole 64 bits
    assign nextFlags.n = accNext[2*`EX_XLEN-1];

    // --------------------------------------------------
    // HI/LO registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
            accQ <= '0;
        else if (accWrite != NONE)
            accQ <= accNext;
    end

    assign hi = accQ[2*`EX_XLEN-1:`EX_XLEN];
    assign lo = accQ[MSB:0];

endmodule

`default_nettype wire

// ==== logic/ex_alu.sv ====
/*
 * Combinational ALU of the execute stage.
 * Covers the SPECIAL arithmetic, logic, compare and shift group plus the
 * SPECIAL2 leading zero and one counts, with c, z, o and n flags.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_alu (
    input  isa_pkg::funct_e         op,
    input  isa_pkg::opClass_e       opClass,
    input  logic [`EX_XLEN-1:0]     a,
    input  logic [`EX_XLEN-1:0]     b,
    output logic [`EX_XLEN-1:0]     result,
    output ex_pkg::exFlags_t        flags
);
    import isa_pkg::*;

    localparam int MSB  = `EX_XLEN - 1;
    localparam int SHW  = $clog2(`EX_XLEN);
    localparam int CNTW = SHW + 1;

    logic                   subOp;
    logic [`EX_XLEN-1:0]    bOp;
    logic [`EX_XLEN:0]      sum;    // Carry in top bit
    logic                   ovf;
    logic [SHW-1:0]         shamt;

    // Run of bitVal starting at the MSB
    function automatic logic [CNTW-1:0] leadCount(input logic [`EX_XLEN-1:0] w,
                                                  input logic bitVal);
        logic [CNTW-1:0] cnt;
        logic            stop;
        cnt  = '0;
        stop = 1'b0;
        for (int i = MSB; i >= 0; i--)
        begin
            if (!stop && (w[i] == bitVal))
                cnt = cnt + 1'b1;
            else
                stop = 1'b1;
        end
        return cnt;
    endfunction

    assign subOp = (opClass == SPECIAL) && ((op == SUB) || (op == SUBU));
    assign bOp   = subOp ? ~b : b;
    assign sum   = {1'b0, a} + {1'b0, bOp} + {{`EX_XLEN{1'b0}}, subOp};
    assign ovf   = (a[MSB] == bOp[MSB]) && (sum[MSB] != a[MSB]);
    assign shamt = a[SHW-1:0];  // MIPS takes the amount from rs

    always_comb
    begin
        result = '0;
        flags  = '0;

        if (opClass == SPECIAL)
        begin
            case (op)
                ADD, SUB:
                begin
                    result  = sum[MSB:0];
                    flags.c = sum[`EX_XLEN];
                    flags.o = ovf;
                end
                ADDU, SUBU:
                begin
                    result  = sum[MSB:0];
                    flags.c = sum[`EX_XLEN];
                end
                AND:  result = a & b;
                OR:   result = a | b;
                XOR:  result = a ^ b;
                NOR:  result = ~(a | b);
                SLT:  result = {{MSB{1'b0}}, $signed(a) < $signed(b)};
                SLTU: result = {{MSB{1'b0}}, a < b};
                SLLV: result = b << shamt;
                SRLV: result = b >> shamt;
                SRAV: result = $signed(b) >>> shamt;
                default: ;
            endcase
        end
        else
        begin
            case (funct2_e'(op))
                CLZ:     result = {{(`EX_XLEN-CNTW){1'b0}}, leadCount(a, 1'b0)};
                CLO:     result = {{(`EX_XLEN-CNTW){1'b0}}, leadCount(a, 1'b1)};
                default: ;
            endcase
        end

        flags.z = (result == '0);
        flags.n = result[MSB];
    end

endmodule

`default_nettype wire

// ==== logic/ex_control.sv ====
/*
 * Execute control: decodes class and funct, picks the ALU, accumulator or
 * product as the result, and gates regWrite for accumulator writes.
 * Purely combinational; the valid flag stays with the top level.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_control (
    input  ex_pkg::exIssue_t        instr,
    input  logic [`EX_XLEN-1:0]     aluResult,
    input  ex_pkg::exFlags_t        aluFlags,
    input  logic [2*`EX_XLEN-1:0]   product,
    input  logic [`EX_XLEN-1:0]     hi,
    input  logic [`EX_XLEN-1:0]     lo,
    input  logic [`EX_XLEN-1:0]     accNextLo,
    input  ex_pkg::exFlags_t        accNextFlags,
    output logic                    signedOp,
    output ex_pkg::accOp_e          accWrite,
    output ex_pkg::exResult_t       result
);
    import isa_pkg::*;
    import ex_pkg::*;

    localparam int MSB = `EX_XLEN - 1;

    // z and n of a plain register read
    function automatic exFlags_t readFlags(input logic [`EX_XLEN-1:0] v);
        exFlags_t f;
        f   = '0;
        f.z = (v == '0);
        f.n = v[MSB];
        return f;
    endfunction

    always_comb
    begin
        result      = '0;           // Unknown funct stays all zero
        result.dest = instr.dest;
        result.pc   = instr.pc;
        accWrite    = NONE;
        signedOp    = 1'b1;         // Only MULTU and MADDU clear it

        if (instr.opClass == SPECIAL)
        begin
            case (instr.funct)
                ADD, ADDU, SUB, SUBU, AND, OR, XOR, NOR,
                SLT, SLTU, SLLV, SRLV, SRAV:
                begin
                    result.value    = aluResult;
                    result.flags    = aluFlags;
                    result.regWrite = instr.regWrite;
                end
                MFHI:
                begin
                    result.value    = hi;
                    result.flags    = readFlags(hi);
                    result.regWrite = instr.regWrite;
                end
                MFLO:
                begin
                    result.value    = lo;
                    result.flags    = readFlags(lo);
                    result.regWrite = instr.regWrite;
                end
                MULT: accWrite = LOAD_PRODUCT;
                MULTU:
                begin
                    signedOp = 1'b0;
                    accWrite = LOAD_PRODUCT;
                end
                MTHI: accWrite = WRITE_HI;
                MTLO: accWrite = WRITE_LO;
                default: ;
            endcase
        end
        else
        begin
            case (funct2_e'(instr.funct))
                CLZ, CLO:
                begin
                    result.value    = aluResult;
                    result.flags    = aluFlags;
                    result.regWrite = instr.regWrite;
                end
                MUL:
                begin
                    result.value    = product[MSB:0];
                    result.flags.c  = |product[2*`EX_XLEN-1:`EX_XLEN];
                    result.flags.o  = |product[2*`EX_XLEN-1:`EX_XLEN];
                    result.flags.z  = (product[MSB:0] == '0);
                    result.flags.n  = product[MSB];
                    result.regWrite = instr.regWrite;
                end
                MADD: accWrite = ADD_PRODUCT;
                MADDU:
                begin
                    signedOp = 1'b0;
                    accWrite = ADD_PRODUCT;
                end
                MSUB: accWrite = SUB_PRODUCT;
                default: ;
            endcase
        end

        // Accumulator writes report the new LO, regWrite stays low
        if (accWrite != NONE)
        begin
            result.value = accNextLo;
            result.flags = accNextFlags;
        end
    end

endmodule

`default_nettype wire

// ==== logic/ex_defs.svh ====
/*
 * Width definitions shared by the execute stage packages and units.
 * Include this header ahead of any package or module that sizes a
 * data word, a register index or a funct field.
 */

`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Data word width, the only width meant to change
`define EX_XLEN 32

`define EX_REGW 5    // Register file index
`define EX_FUNCTW 6  // Funct field of R-type words

`endif

// ==== logic/ex_mul.sv ====
/*
 * Combinational 32x32 multiplier giving the full 64-bit product.
 * signedOp picks sign or zero extension of both operands, so one
 * signed multiply serves MULT, MULTU, MUL, MADD, MADDU and MSUB.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_mul (
    input  logic [`EX_XLEN-1:0]     a,
    input  logic [`EX_XLEN-1:0]     b,
    input  logic                    signedOp,
    output logic [2*`EX_XLEN-1:0]   product
);

    localparam int MSB = `EX_XLEN - 1;

    // One extra bit each so unsigned values stay positive
    logic signed [`EX_XLEN:0]       aExt;
    logic signed [`EX_XLEN:0]       bExt;
    logic signed [2*`EX_XLEN-1:0]   full;

    // --------------------------------------------------
    // Operand extension
    // --------------------------------------------------
    assign aExt = {signedOp & a[MSB], a};
    assign bExt = {signedOp & b[MSB], b};

    // --------------------------------------------------
    // Product
    // --------------------------------------------------
    assign full = aExt * bExt;      // Low 64 bits of the extended product

    assign product = full;

endmodule

`default_nettype wire

// ==== logic/ex_pkg.sv ====
/*
 * Datapath types of the execute stage: the issued instruction, the flag
 * set, the stage result and the accumulator action code.
 */

`default_nettype none

`include "ex_defs.svh"

package ex_pkg;

    typedef struct packed {
        logic c;  // Carry out
        logic z;  // Zero
        logic o;  // Signed overflow
        logic n;  // Negative
    } exFlags_t;

    // Decoded instruction as it enters the stage
    typedef struct packed {
        isa_pkg::opClass_e      opClass;
        isa_pkg::funct_e        funct;     // SPECIAL2 codes carried as raw bits
        logic [`EX_XLEN-1:0]    a;         // rs value
        logic [`EX_XLEN-1:0]    b;         // rt value
        logic [`EX_REGW-1:0]    dest;
        logic                   regWrite;
        logic [`EX_XLEN-1:0]    pc;
    } exIssue_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]    value;
        exFlags_t               flags;
        logic [`EX_REGW-1:0]    dest;
        logic                   regWrite;
        logic [`EX_XLEN-1:0]    pc;
    } exResult_t;

    typedef enum logic [2:0] {
        NONE, LOAD_PRODUCT, ADD_PRODUCT, SUB_PRODUCT, WRITE_HI, WRITE_LO
    } accOp_e;

endpackage

`default_nettype wire

// ==== logic/ex_stage.sv ====
/*
 * Top level of the execute stage: issue register, the parallel compute
 * units and the result register. Two cycles from inValid to outValid,
 * one instruction per cycle, no back-pressure.
 */

`timescale 1ns/1ps
`default_nettype none

`include "ex_defs.svh"

module ex_stage (
    input  logic                clk,
    input  logic                rstN,
    input  logic                inValid,
    input  ex_pkg::exIssue_t    inInstr,
    output logic                outValid,
    output ex_pkg::exResult_t   outResult
);
    import ex_pkg::*;

    logic                       issueValid;
    exIssue_t                   issueQ;

    logic [`EX_XLEN-1:0]        aluResult;
    exFlags_t                   aluFlags;
    logic                       signedOp;
    logic [2*`EX_XLEN-1:0]      product;
    logic [`EX_XLEN-1:0]        hi;
    logic [`EX_XLEN-1:0]        lo;
    logic [`EX_XLEN-1:0]        accNextLo;
    exFlags_t                   accNextFlags;
    accOp_e                     accReq;
    accOp_e                     accGated;
    exResult_t                  ctrlResult;

    // --------------------------------------------------
    // Issue register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            issueValid <= 1'b0;
            issueQ     <= '0;
        end
        else
        begin
            issueValid <= inValid;
            issueQ     <= inInstr;
        end
    end

    ex_alu uAlu (
        .op      (issueQ.funct),
        .opClass (issueQ.opClass),
        .a       (issueQ.a),
        .b       (issueQ.b),
        .result  (aluResult),
        .flags   (aluFlags)
    );

    ex_mul uMul (
        .a        (issueQ.a),
        .b        (issueQ.b),
        .signedOp (signedOp),
        .product  (product)
    );

    // HI/LO only move for a valid instruction
    assign accGated = issueValid ? accReq : NONE;

    ex_acc uAcc (
        .clk       (clk),
        .rstN      (rstN),
        .accWrite  (accGated),
        .product   (product),
        .a         (issueQ.a),
        .hi        (hi),
        .lo        (lo),
        .nextLo    (accNextLo),
        .nextFlags (accNextFlags)
    );

    ex_control uCtrl (
        .instr        (issueQ),
        .aluResult    (aluResult),
        .aluFlags     (aluFlags),
        .product      (product),
        .hi           (hi),
        .lo           (lo),
        .accNextLo    (accNextLo),
        .accNextFlags (accNextFlags),
        .signedOp     (signedOp),
        .accWrite     (accReq),
        .result       (ctrlResult)
    );

    // --------------------------------------------------
    // Result register
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            outValid  <= 1'b0;
            outResult <= '0;
        end
        else
        begin
            outValid <= issueValid;
            if (issueValid)
                outResult <= ctrlResult;  // Holds the last result when idle
        end
    end

endmodule

`default_nettype wire

// ==== logic/isa_pkg.sv ====
/*
 * Instruction encoding for the execute stage.
 * SPECIAL and SPECIAL2 reuse funct values, so each class has its own enum
 * and a funct is only meaningful together with its class.
 */

`default_nettype none

`include "ex_defs.svh"

package isa_pkg;

    typedef enum logic {
        SPECIAL  = 1'b0,  // Plain ALU and HI/LO group
        SPECIAL2 = 1'b1   // MUL, MADD, MSUB, CLZ, CLO
    } opClass_e;

    // --------------------------------------------------
    // SPECIAL funct codes
    // --------------------------------------------------
    typedef enum logic [`EX_FUNCTW-1:0] {
        SLLV  = 6'h04, SRLV  = 6'h06, SRAV  = 6'h07,
        MFHI  = 6'h10, MTHI  = 6'h11, MFLO  = 6'h12, MTLO = 6'h13,
        MULT  = 6'h18, MULTU = 6'h19,
        ADD   = 6'h20, ADDU  = 6'h21, SUB   = 6'h22, SUBU = 6'h23,
        AND   = 6'h24, OR    = 6'h25, XOR   = 6'h26, NOR  = 6'h27,
        SLT   = 6'h2a, SLTU  = 6'h2b
    } funct_e;

    // --------------------------------------------------
    // SPECIAL2 funct codes
    // --------------------------------------------------
    typedef enum logic [`EX_FUNCTW-1:0] {
        MADD  = 6'h00,
        MADDU = 6'h01,
        MUL   = 6'h02,
        MSUB  = 6'h04,
        CLZ   = 6'h20,
        CLO   = 6'h21
    } funct2_e;

endpackage

`default_nettype wire
